// ==== compile.f ====
design/lsu_pkg.sv
design/lsu_agu.sv
design/lsu_bus_timer.sv
design/lsu_fsm.sv
design/lsu_data_align.sv
design/lsu_top.sv
test/tb_clock_gen.sv
test/tb_lsu.sv

// ==== design/lsu_agu.sv ====
`timescale 1ns/10ps

module lsu_agu (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             accept_i,
    input  lsu_pkg::lsu_op_e                 op_i,
    input  logic [lsu_pkg::XLEN-1:0]         base_i,
    input  logic [lsu_pkg::XLEN-1:0]         imm_i,
    input  logic [lsu_pkg::XLEN-1:0]         wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]   trans_id_i,
    output logic [lsu_pkg::XLEN-1:0]         addr_o,
    output lsu_pkg::lsu_op_e                 op_o,
    output logic [lsu_pkg::SEL_W-1:0]        sel_o,
    output logic [lsu_pkg::XLEN-1:0]         wdata_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0]   trans_id_o,
    output logic                             misaligned_o
);

    logic [lsu_pkg::XLEN-1:0]  addr_d;
    logic [1:0]                size_d;
    logic [lsu_pkg::SEL_W-1:0] sel_d;
    logic                      misaligned_d;

    // effective address, wraps like the core adder
    assign addr_d = base_i + imm_i;
    assign size_d = lsu_pkg::op_size(op_i);

    // byte selects and alignment from the low address bits
    always_comb begin
        sel_d        = '1;
        misaligned_d = 1'b0;
        case (size_d)
            lsu_pkg::SIZE_BYTE: begin
                sel_d = {{(lsu_pkg::SEL_W-1){1'b0}}, 1'b1} << addr_d[1:0];
            end
            lsu_pkg::SIZE_HALF: begin
                sel_d        = {{(lsu_pkg::SEL_W-2){1'b0}}, 2'b11} << addr_d[1:0];
                misaligned_d = addr_d[0];
            end
            default: begin
                misaligned_d = |addr_d[1:0];
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // request register, held until the next accept
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            misaligned_o <= 1'b0;
        end else if (accept_i) begin
            misaligned_o <= misaligned_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            addr_o     <= addr_d;
            op_o       <= op_i;
            sel_o      <= sel_d;
            wdata_o    <= wdata_i;
            trans_id_o <= trans_id_i;
        end
    end

endmodule

// ==== design/lsu_bus_timer.sv ====
`timescale 1ns/10ps

module lsu_bus_timer #(
    parameter int unsigned TimeoutCycles = 16
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic run_i,
    output logic expired_o
);

    localparam int unsigned CntW = $clog2(TimeoutCycles + 1);

    logic [CntW-1:0] count_q;

    // edges seen since the bus cycle opened
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (!run_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 1'b1;
        end
    end

    // the edge closing this cycle is the last one allowed
    assign expired_o = run_i && (count_q == CntW'(TimeoutCycles - 1));

endmodule

// ==== design/lsu_data_align.sv ====
`timescale 1ns/10ps

module lsu_data_align (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             capture_i,
    input  logic                             ex_valid_i,
    input  lsu_pkg::exc_cause_e              ex_cause_i,
    input  lsu_pkg::lsu_op_e                 op_i,
    input  logic [lsu_pkg::XLEN-1:0]         addr_i,
    input  logic [lsu_pkg::XLEN-1:0]         wdata_i,
    input  logic [lsu_pkg::XLEN-1:0]         wb_dat_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]   trans_id_i,
    output logic [lsu_pkg::XLEN-1:0]         wb_dat_o,
    output logic [lsu_pkg::XLEN-1:0]         res_data_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0]   res_trans_id_o,
    output logic                             res_ex_valid_o,
    output lsu_pkg::exc_cause_e              res_ex_cause_o
);

    logic [1:0]               size;
    logic                     uns;
    logic [lsu_pkg::XLEN-1:0] rdata_shifted;
    logic [lsu_pkg::XLEN-1:0] load_data;
    logic [lsu_pkg::XLEN-1:0] result_d;

    assign size = lsu_pkg::op_size(op_i);
    assign uns  = lsu_pkg::op_is_unsigned(op_i);

    // store data copied onto every lane, sel picks the right one
    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: wb_dat_o = {4{wdata_i[7:0]}};
            lsu_pkg::SIZE_HALF: wb_dat_o = {2{wdata_i[15:0]}};
            default:            wb_dat_o = wdata_i;
        endcase
    end

    // ------------------------------------------------------------------------
    // load extraction and extension
    // ------------------------------------------------------------------------
    assign rdata_shifted = wb_dat_i >> {addr_i[1:0], 3'b000};

    always_comb begin
        case (size)
            lsu_pkg::SIZE_BYTE: begin
                load_data = {{(lsu_pkg::XLEN-8){rdata_shifted[7] & ~uns}}, rdata_shifted[7:0]};
            end
            lsu_pkg::SIZE_HALF: begin
                load_data = {{(lsu_pkg::XLEN-16){rdata_shifted[15] & ~uns}},
                             rdata_shifted[15:0]};
            end
            default: load_data = rdata_shifted;
        endcase
    end

    // faulting address takes priority, stores report zero
    assign result_d = ex_valid_i ? addr_i :
                      lsu_pkg::op_is_store(op_i) ? '0 : load_data;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            res_ex_valid_o <= 1'b0;
        end else if (capture_i) begin
            res_ex_valid_o <= ex_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture_i) begin
            res_data_o     <= result_d;
            res_trans_id_o <= trans_id_i;
            res_ex_cause_o <= ex_cause_i;
        end
    end

endmodule

// ==== design/lsu_fsm.sv ====
`timescale 1ns/10ps

module lsu_fsm (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                req_valid_i,
    input  logic                misaligned_i,
    input  logic                is_store_i,
    input  logic                wb_ack_i,
    input  logic                expired_i,
    output logic                req_ready_o,
    output logic                accept_o,
    output logic                wb_cyc_o,
    output logic                wb_stb_o,
    output logic                wb_we_o,
    output logic                run_o,
    output logic                capture_o,
    output logic                ex_valid_o,
    output logic                res_valid_o,
    output lsu_pkg::exc_cause_e ex_cause_o
);

    localparam logic [1:0] StIdle   = 2'd0;
    localparam logic [1:0] StAccess = 2'd1;
    localparam logic [1:0] StResp   = 2'd2;

    logic [1:0] state_q;
    logic [1:0] state_d;
    logic       bus_active;
    logic       acked;
    logic       finish;

    // ------------------------------------------------------------------------
    // outputs decoded from the state
    // ------------------------------------------------------------------------
    assign req_ready_o = (state_q == StIdle);
    assign accept_o    = req_valid_i && req_ready_o;
    assign res_valid_o = (state_q == StResp);

    // misaligned requests never reach the bus
    assign bus_active = (state_q == StAccess) && !misaligned_i;
    assign wb_cyc_o   = bus_active;
    assign wb_stb_o   = bus_active;
    assign wb_we_o    = bus_active && is_store_i;
    assign run_o      = bus_active;

    // ack on the expiring edge still wins
    assign acked     = bus_active && wb_ack_i;
    assign finish    = (state_q == StAccess) && (misaligned_i || acked || expired_i);
    assign capture_o = finish;

    assign ex_valid_o = (state_q == StAccess) && (misaligned_i || !acked);

    always_comb begin
        if (misaligned_i) begin
            ex_cause_o = is_store_i ? lsu_pkg::ST_ADDR_MISALIGNED
                                    : lsu_pkg::LD_ADDR_MISALIGNED;
        end else begin
            ex_cause_o = is_store_i ? lsu_pkg::ST_ACCESS_FAULT
                                    : lsu_pkg::LD_ACCESS_FAULT;
        end
    end

    // ------------------------------------------------------------------------
    // state register
    // ------------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            StIdle:   if (accept_o) state_d = StAccess;
            StAccess: if (finish) state_d = StResp;
            default:  state_d = StIdle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= StIdle;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned SEL_W      = XLEN / 8;
    localparam int unsigned TRANS_ID_W = 3;

    // access sizes as returned by op_size
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // ------------------------------------------------------------------------
    // operations and exception causes
    // ------------------------------------------------------------------------
    typedef enum logic [3:0] {
        LB  = 4'd0,
        LH  = 4'd1,
        LW  = 4'd2,
        LBU = 4'd3,
        LHU = 4'd4,
        SB  = 4'd5,
        SH  = 4'd6,
        SW  = 4'd7
    } lsu_op_e;

    // riscv mcause encodings
    typedef enum logic [3:0] {
        LD_ADDR_MISALIGNED = 4'd4,
        LD_ACCESS_FAULT    = 4'd5,
        ST_ADDR_MISALIGNED = 4'd6,
        ST_ACCESS_FAULT    = 4'd7
    } exc_cause_e;

    function automatic logic [1:0] op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return SIZE_BYTE;
            LH, LHU, SH: return SIZE_HALF;
            default:     return SIZE_WORD;
        endcase
    endfunction

    function automatic logic op_is_store(lsu_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    function automatic logic op_is_unsigned(lsu_op_e op);
        return (op == LBU) || (op == LHU);
    endfunction

endpackage

// ==== design/lsu_top.sv ====
`timescale 1ns/10ps

module lsu_top #(
    parameter int unsigned TimeoutCycles = 16
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // request
    input  logic                             req_valid_i,
    input  lsu_pkg::lsu_op_e                 req_op_i,
    input  logic [lsu_pkg::XLEN-1:0]         req_base_i,
    input  logic [lsu_pkg::XLEN-1:0]         req_imm_i,
    input  logic [lsu_pkg::XLEN-1:0]         req_wdata_i,
    input  logic [lsu_pkg::TRANS_ID_W-1:0]   req_trans_id_i,
    output logic                             req_ready_o,
    // result
    output logic                             res_valid_o,
    output logic [lsu_pkg::TRANS_ID_W-1:0]   res_trans_id_o,
    output logic [lsu_pkg::XLEN-1:0]         res_data_o,
    output logic                             res_ex_valid_o,
    output lsu_pkg::exc_cause_e              res_ex_cause_o,
    // wishbone master
    output logic                             wb_cyc_o,
    output logic                             wb_stb_o,
    output logic                             wb_we_o,
    output logic [lsu_pkg::XLEN-1:0]         wb_adr_o,
    output logic [lsu_pkg::SEL_W-1:0]        wb_sel_o,
    output logic [lsu_pkg::XLEN-1:0]         wb_dat_o,
    input  logic [lsu_pkg::XLEN-1:0]         wb_dat_i,
    input  logic                             wb_ack_i
);

    logic                           accept;
    logic [lsu_pkg::XLEN-1:0]       addr;
    lsu_pkg::lsu_op_e               op;
    logic [lsu_pkg::XLEN-1:0]       wdata;
    logic [lsu_pkg::TRANS_ID_W-1:0] trans_id;
    logic                           misaligned;
    logic                           run;
    logic                           expired;
    logic                           capture;
    logic                           ex_valid;
    lsu_pkg::exc_cause_e            ex_cause;

    assign wb_adr_o = {addr[lsu_pkg::XLEN-1:2], 2'b00};

    lsu_agu i_agu (
        .clk_i, .rst_ni, .accept_i(accept), .op_i(req_op_i), .base_i(req_base_i),
        .imm_i(req_imm_i), .wdata_i(req_wdata_i), .trans_id_i(req_trans_id_i),
        .addr_o(addr), .op_o(op), .sel_o(wb_sel_o), .wdata_o(wdata),
        .trans_id_o(trans_id), .misaligned_o(misaligned)
    );

    lsu_bus_timer #(.TimeoutCycles(TimeoutCycles)) i_timer (
        .clk_i, .rst_ni, .run_i(run), .expired_o(expired)
    );

    lsu_fsm i_fsm (
        .clk_i, .rst_ni, .req_valid_i, .misaligned_i(misaligned),
        .is_store_i(lsu_pkg::op_is_store(op)), .wb_ack_i, .expired_i(expired),
        .req_ready_o, .accept_o(accept), .wb_cyc_o, .wb_stb_o, .wb_we_o, .run_o(run),
        .capture_o(capture), .ex_valid_o(ex_valid), .res_valid_o, .ex_cause_o(ex_cause)
    );

    lsu_data_align i_align (
        .clk_i, .rst_ni, .capture_i(capture), .ex_valid_i(ex_valid), .ex_cause_i(ex_cause),
        .op_i(op), .addr_i(addr), .wdata_i(wdata), .wb_dat_i, .trans_id_i(trans_id),
        .wb_dat_o, .res_data_o, .res_trans_id_o, .res_ex_valid_o, .res_ex_cause_o
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_lsu -Mdir obj_dir

# a fatal check stops the binary with an error status
output=$(./obj_dir/Vtb_lsu || true)
echo "$output"
if grep -q "ALL CHECKS PASSED" <<< "$output"; then
    exit 0
fi
exit 1

// ==== test/lsu_patterns.hex ====
// op base imm wdata id then expected result ex cause
// op 0..7 is LB LH LW LBU LHU SB SH SW and bit 31 addresses never ack
7 00000100 00000000 11223344 0 00000000 0 0
5 00000100 00000001 000000F0 1 00000000 0 0
6 00000100 00000002 0000ABCD 2 00000000 0 0
0 00000100 00000001 00000000 3 FFFFFFF0 0 0
3 00000100 00000001 00000000 4 000000F0 0 0
1 00000100 00000002 00000000 5 FFFFABCD 0 0
4 00000100 00000002 00000000 6 0000ABCD 0 0
2 00000100 00000000 00000000 7 ABCDF044 0 0
0 00000100 00000000 00000000 0 00000044 0 0
7 00000200 FFFFFFFC 7F00FF80 1 00000000 0 0
1 000001F0 0000000C 00000000 2 FFFFFF80 0 0
0 000001FF 00000000 00000000 3 0000007F 0 0
4 000001FA 00000004 00000000 4 00007F00 0 0
1 00000100 00000001 00000000 5 00000101 1 4
2 000000FF 00000003 00000000 6 00000102 1 4
6 00000200 00000003 0000BEEF 7 00000203 1 6
7 00000300 00000001 CAFEF00D 0 00000301 1 6
2 80000000 00000010 00000000 1 80000010 1 5
5 80000000 00000003 000000AA 2 80000003 1 7
2 00000100 00000000 00000000 3 ABCDF044 0 0

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int unsigned PeriodNs    = 40,
    parameter int unsigned ResetCycles = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PeriodNs / 2) clk_o = ~clk_o;
    end

    // reset released on a rising edge
    initial begin
        rst_no = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        rst_no <= 1'b1;
    end

endmodule

// ==== test/tb_lsu.sv ====
`timescale 1ns/10ps

module tb_lsu;

    localparam int unsigned TimeoutCycles  = 16;
    localparam int unsigned ClkPeriodNs    = 40;
    localparam int unsigned ResetCycles    = 8;
    localparam int unsigned NumPatterns    = 20;
    localparam int unsigned MemWords       = 256;
    localparam int unsigned WatchdogCycles = NumPatterns * (TimeoutCycles + 8) + ResetCycles;
    localparam logic [15:0] LfsrSeed       = 16'd89;

    logic                               clk_i;
    logic                               rst_ni;
    logic                               req_valid_i;
    lsu_pkg::lsu_op_e                   req_op_i;
    logic [lsu_pkg::XLEN-1:0]           req_base_i;
    logic [lsu_pkg::XLEN-1:0]           req_imm_i;
    logic [lsu_pkg::XLEN-1:0]           req_wdata_i;
    logic [lsu_pkg::TRANS_ID_W-1:0]     req_trans_id_i;
    logic                               req_ready_o;
    logic                               res_valid_o;
    logic [lsu_pkg::TRANS_ID_W-1:0]     res_trans_id_o;
    logic [lsu_pkg::XLEN-1:0]           res_data_o;
    logic                               res_ex_valid_o;
    lsu_pkg::exc_cause_e                res_ex_cause_o;
    logic                               wb_cyc_o;
    logic                               wb_stb_o;
    logic                               wb_we_o;
    logic [lsu_pkg::XLEN-1:0]           wb_adr_o;
    logic [lsu_pkg::SEL_W-1:0]          wb_sel_o;
    logic [lsu_pkg::XLEN-1:0]           wb_dat_o;
    logic [lsu_pkg::XLEN-1:0]           wb_dat_i = '0;
    logic                               wb_ack_i = 1'b0;

    // eight words per request: op base imm wdata id result ex cause
    logic [31:0] patterns [NumPatterns*8];
    logic [31:0] mem [MemWords];
    logic [1:0]  wait_cnt;
    logic [1:0]  wait_target;
    logic [15:0] ack_lfsr;
    logic [lsu_pkg::XLEN-1:0] exp_adr;
    int          beats_seen;

    tb_clock_gen #(.PeriodNs(ClkPeriodNs), .ResetCycles(ResetCycles)) i_clk_gen (
        .clk_o(clk_i),
        .rst_no(rst_ni)
    );

    lsu_top #(.TimeoutCycles(TimeoutCycles)) i_dut (.*);

    function automatic logic [15:0] lfsr_step(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic draw_delay(inout logic [15:0] state, output logic [1:0] delay);
        delay = 2'd0;
        for (int i = 0; i < 2; i++) begin
            delay = {delay[0], state[0]};
            state = lfsr_step(state);
        end
    endtask

    task automatic end_in_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual == expected) else begin
            $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
            end_in_failure();
        end
    endtask

    // ------------------------------------------------------------------------
    // wishbone memory model
    // ------------------------------------------------------------------------
    // addresses with bit 31 set are never acknowledged
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            wb_ack_i <= 1'b0;
            wb_dat_i <= '0;
            wait_cnt <= 2'd0;
            ack_lfsr = LfsrSeed;
            draw_delay(ack_lfsr, wait_target);
            for (int i = 0; i < MemWords; i++) begin
                mem[i] <= {16'hC0DE, 8'(i), ~8'(i)};
            end
        end else if (wb_ack_i) begin
            wb_ack_i <= 1'b0;
        end else if (wb_cyc_o && wb_stb_o && !wb_adr_o[31]) begin
            check_value("wb_adr_o", exp_adr, wb_adr_o);
            if (wait_cnt == wait_target) begin
                wb_ack_i <= 1'b1;
                wb_dat_i <= mem[wb_adr_o[9:2]];
                for (int b = 0; b < 4; b++) begin
                    if (wb_we_o && wb_sel_o[b])
                        mem[wb_adr_o[9:2]][8*b +: 8] <= wb_dat_o[8*b +: 8];
                end
                wait_cnt <= 2'd0;
                draw_delay(ack_lfsr, wait_target);
            end else begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end else if (!wb_cyc_o) begin
            wait_cnt <= 2'd0;
        end
    end

    // result beats counted apart from the driver
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            beats_seen <= 0;
        end else if (res_valid_o) begin
            beats_seen <= beats_seen + 1;
        end
    end

    // ------------------------------------------------------------------------
    // pattern driver and result checker
    // ------------------------------------------------------------------------
    initial begin
        logic [15:0] gap_lfsr;
        logic [1:0]  gap;
        int          base;
        int          cyc_cycles;
        logic        misaligned;

        req_valid_i    = 1'b0;
        req_op_i       = lsu_pkg::LB;
        req_base_i     = '0;
        req_imm_i      = '0;
        req_wdata_i    = '0;
        req_trans_id_i = '0;
        exp_adr        = '0;
        gap_lfsr       = LfsrSeed;
        $readmemh("test/lsu_patterns.hex", patterns);

        // idle outputs during reset and on the first edge after it
        do begin
            @(posedge clk_i);
            check_value("wb_cyc_o", 32'd0, 32'(wb_cyc_o));
            check_value("wb_stb_o", 32'd0, 32'(wb_stb_o));
            check_value("res_valid_o", 32'd0, 32'(res_valid_o));
            check_value("req_ready_o", 32'd1, 32'(req_ready_o));
        end while (!rst_ni);

        for (int p = 0; p < NumPatterns; p++) begin
            base = p * 8;
            draw_delay(gap_lfsr, gap);
            repeat (gap) begin
                @(posedge clk_i);
                check_value("res_valid_o", 32'd0, 32'(res_valid_o));
            end
            // word address of the effective address
            exp_adr = (patterns[base+1] + patterns[base+2]) & 32'hFFFF_FFFC;
            req_valid_i    <= 1'b1;
            req_op_i       <= lsu_pkg::lsu_op_e'(patterns[base][3:0]);
            req_base_i     <= patterns[base+1];
            req_imm_i      <= patterns[base+2];
            req_wdata_i    <= patterns[base+3];
            req_trans_id_i <= patterns[base+4][lsu_pkg::TRANS_ID_W-1:0];
            @(posedge clk_i);
            assert (req_ready_o) else begin
                $display("request %0d was not accepted although the unit was idle", p);
                end_in_failure();
            end
            // the previous beat lasted one cycle only
            check_value("res_valid_o", 32'd0, 32'(res_valid_o));
            req_valid_i <= 1'b0;

            cyc_cycles = 0;
            do begin
                @(posedge clk_i);
                if (wb_cyc_o) begin
                    cyc_cycles++;
                end
                check_value("req_ready_o", 32'd0, 32'(req_ready_o));
            end while (!res_valid_o);

            check_value("res_trans_id_o", patterns[base+4], 32'(res_trans_id_o));
            check_value("res_data_o", patterns[base+5], res_data_o);
            check_value("res_ex_valid_o", patterns[base+6], 32'(res_ex_valid_o));
            check_value("wb_cyc_o", 32'd0, 32'(wb_cyc_o));
            if (patterns[base+6][0]) begin
                check_value("res_ex_cause_o", patterns[base+7], 32'(res_ex_cause_o));
                misaligned = (patterns[base+7][3:0] == lsu_pkg::LD_ADDR_MISALIGNED) ||
                             (patterns[base+7][3:0] == lsu_pkg::ST_ADDR_MISALIGNED);
                // no bus cycle when misaligned, full timeout on a fault
                check_value("wb_cyc_o cycles", misaligned ? 32'd0 : TimeoutCycles,
                            32'(cyc_cycles));
            end
        end

        @(posedge clk_i);
        check_value("res_valid_o", 32'd0, 32'(res_valid_o));
        if (beats_seen == NumPatterns) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("the number of result beats differs from the number of requests");
            end_in_failure();
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriodNs);
        $display("watchdog expired because a request got no result in time");
        end_in_failure();
    end

endmodule
